// File: logic/icache_pkg.sv
`default_nettype none

package icache_pkg;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // AXI read response codes in use
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REQ,
        WAIT,
        RESP
    } state_t;

endpackage

`default_nettype wire

// File: logic/ram_if.sv
`default_nettype none

interface ram_if #(
    parameter type payload_t = logic,
    parameter int DEPTH_BITS = 4
) ();

    logic [DEPTH_BITS-1:0] addr;
    logic                  we;
    payload_t              wdata;
    // entry at the previous cycle's addr
    payload_t              rdata;

    modport master (
        output addr,
        output we,
        output wdata,
        input  rdata
    );

    modport slave (
        input  addr,
        input  we,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: logic/icache_array.sv
`default_nettype none

module icache_array #(
    parameter type payload_t = logic,
    parameter int DEPTH_BITS = 4
) (
    input wire clk,
    ram_if.slave port
);

    localparam int DEPTH = 2 ** DEPTH_BITS;

    payload_t mem [DEPTH];

    // read beside a write returns the old entry
    always_ff @(posedge clk)
    begin
        if (port.we)
        begin
            mem[port.addr] <= port.wdata;
        end
        port.rdata <= mem[port.addr];
    end

endmodule

`default_nettype wire

// File: logic/icache_ctrl.sv
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int INDEX_BITS = 4,
    parameter type tag_t = logic [ADDR_W-INDEX_BITS-3:0]
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        flush,

    input  wire        cpu_req_valid,
    input  wire addr_t cpu_req_addr,
    output logic       cpu_req_ready,
    output logic       cpu_rsp_valid,
    output word_t      cpu_rsp_data,
    output logic       cpu_rsp_err,

    output addr_t      m_araddr,
    output logic       m_arvalid,
    input  wire        m_arready,
    input  wire word_t m_rdata,
    input  wire resp_t m_rresp,
    input  wire        m_rvalid,
    output logic       m_rready,

    ram_if.master      tag_port,
    ram_if.master      data_port
);

    localparam int LINES = 2 ** INDEX_BITS;

    state_t                state;
    state_t                state_next;
    addr_t                 req_addr;
    logic [INDEX_BITS-1:0] cpu_index;
    logic [INDEX_BITS-1:0] req_index;
    logic [INDEX_BITS-1:0] array_addr;
    tag_t                  req_tag;
    logic [LINES-1:0]      valid_bits;
    logic                  accept;
    logic                  hit;
    logic                  r_done;
    logic                  refill_ok;

    assign cpu_index = cpu_req_addr[INDEX_BITS+1:2];
    assign req_index = req_addr[INDEX_BITS+1:2];
    assign req_tag   = req_addr[ADDR_W-1:INDEX_BITS+2];

    assign cpu_req_ready = (state == IDLE) && !flush;
    assign accept        = cpu_req_ready && cpu_req_valid;

    // valid line with a matching tag
    assign hit = valid_bits[req_index] && (tag_port.rdata == req_tag);

    assign r_done    = (state == WAIT) && m_rvalid;
    assign refill_ok = r_done && (m_rresp == OKAY);

    // arrays follow the incoming address while idle
    assign array_addr = (state == IDLE) ? cpu_index : req_index;

    assign tag_port.addr   = array_addr;
    assign tag_port.we     = refill_ok;
    assign tag_port.wdata  = req_tag;
    assign data_port.addr  = array_addr;
    assign data_port.we    = refill_ok;
    assign data_port.wdata = m_rdata;

    assign m_araddr  = req_addr;
    assign m_arvalid = (state == REQ);
    assign m_rready  = (state == WAIT);

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (accept)
                begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP:
            begin
                state_next = hit ? RESP : REQ;
            end
            REQ:
            begin
                if (m_arready)
                begin
                    state_next = WAIT;
                end
            end
            WAIT:
            begin
                if (m_rvalid)
                begin
                    state_next = RESP;
                end
            end
            RESP:
            begin
                state_next = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_addr <= cpu_req_addr;
        end
    end

    // flush only taken while idle
    always_ff @(posedge clk)
    begin
        if (rst || (state == IDLE && flush))
        begin
            valid_bits <= '0;
        end
        else if (refill_ok)
        begin
            valid_bits[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cpu_rsp_valid <= 1'b0;
        end
        else
        begin
            cpu_rsp_valid <= (state == LOOKUP && hit) || r_done;
        end
    end

    // hit word from the data array or the refill beat
    always_ff @(posedge clk)
    begin
        if (state == LOOKUP && hit)
        begin
            cpu_rsp_data <= data_port.rdata;
            cpu_rsp_err  <= 1'b0;
        end
        else if (r_done)
        begin
            cpu_rsp_data <= m_rdata;
            cpu_rsp_err  <= (m_rresp != OKAY);
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_top.sv
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        flush,

    input  wire        cpu_req_valid,
    input  wire addr_t cpu_req_addr,
    output logic       cpu_req_ready,
    output logic       cpu_rsp_valid,
    output word_t      cpu_rsp_data,
    output logic       cpu_rsp_err,

    output addr_t      m_araddr,
    output logic       m_arvalid,
    input  wire        m_arready,
    input  wire word_t m_rdata,
    input  wire resp_t m_rresp,
    input  wire        m_rvalid,
    output logic       m_rready
);

    // address above index and byte offset
    typedef logic [ADDR_W-INDEX_BITS-3:0] tag_t;

    ram_if #(.payload_t(tag_t),  .DEPTH_BITS(INDEX_BITS)) tag_bus ();
    ram_if #(.payload_t(word_t), .DEPTH_BITS(INDEX_BITS)) data_bus ();

    icache_array #(
        .payload_t  (tag_t),
        .DEPTH_BITS (INDEX_BITS)
    ) u_tag_array (
        .clk  (clk),
        .port (tag_bus.slave)
    );

    icache_array #(
        .payload_t  (word_t),
        .DEPTH_BITS (INDEX_BITS)
    ) u_data_array (
        .clk  (clk),
        .port (data_bus.slave)
    );

    icache_ctrl #(
        .INDEX_BITS (INDEX_BITS),
        .tag_t      (tag_t)
    ) u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_data  (cpu_rsp_data),
        .cpu_rsp_err   (cpu_rsp_err),
        .m_araddr      (m_araddr),
        .m_arvalid     (m_arvalid),
        .m_arready     (m_arready),
        .m_rdata       (m_rdata),
        .m_rresp       (m_rresp),
        .m_rvalid      (m_rvalid),
        .m_rready      (m_rready),
        .tag_port      (tag_bus.master),
        .data_port     (data_bus.master)
    );

endmodule

`default_nettype wire

// File: bench/axi_mem_model.sv
`default_nettype none

module axi_mem_model
    import icache_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire addr_t m_araddr,
    input  wire        m_arvalid,
    output logic       m_arready,
    output word_t      m_rdata,
    output resp_t      m_rresp,
    output logic       m_rvalid,
    input  wire        m_rready
);

    timeunit 1ns;
    timeprecision 1ps;

    addr_t addr;
    int    delay;

    // memory contents computed from the address
    function automatic word_t word_at(input addr_t a);
        word_t x;
        x = a ^ 32'hc0de_0000;
        return {x[26:0], x[31:27]};
    endfunction

    initial
    begin
        m_arready <= 1'b0;
        m_rvalid  <= 1'b0;
        m_rdata   <= '0;
        m_rresp   <= OKAY;
        forever
        begin
            @(posedge clk);
            if (!rst && m_arvalid)
            begin
                addr  = m_araddr;
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge clk);
                m_arready <= 1'b1;
                @(posedge clk);
                m_arready <= 1'b0;
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge clk);
                m_rvalid <= 1'b1;
                m_rdata  <= word_at(addr);
                // top quarter of the map answers with an error
                m_rresp  <= (addr[31:30] == 2'b11) ? SLVERR : OKAY;
                do
                begin
                    @(posedge clk);
                end
                while (!m_rready);
                m_rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_icache.sv
`default_nettype none

module tb_icache
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int INDEX_BITS  = 4;
    localparam int LINES       = 2 ** INDEX_BITS;
    localparam int NUM_REQ     = 400;
    localparam int FLUSH_EVERY = 64;
    // a miss with both slave delays at 3 takes 13 cycles from the previous response
    localparam int MAX_CYCLES  = NUM_REQ * 14 + 200;

    logic  clk;
    logic  rst;
    logic  flush;
    logic  cpu_req_valid;
    addr_t cpu_req_addr;
    logic  cpu_req_ready;
    logic  cpu_rsp_valid;
    word_t cpu_rsp_data;
    logic  cpu_rsp_err;
    addr_t m_araddr;
    logic  m_arvalid;
    logic  m_arready;
    word_t m_rdata;
    resp_t m_rresp;
    logic  m_rvalid;
    logic  m_rready;

    int    errors = 0;
    int    hits = 0;
    int    misses = 0;
    int    rsp_taken = 0;
    int    rsp_seen = 0;
    int    ar_count = 0;
    int    cycles = 0;
    addr_t last_araddr;
    logic  model_valid [LINES];
    addr_t model_tag [LINES];

    icache_top #(.INDEX_BITS(INDEX_BITS)) u_icache_top (.*);
    axi_mem_model u_axi_mem_model (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the cache stopped answering after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // bus activity seen from outside the DUT
    always @(posedge clk)
    begin
        if (!rst && m_arvalid && m_arready)
        begin
            ar_count    <= ar_count + 1;
            last_araddr <= m_araddr;
        end
        if (!rst && cpu_rsp_valid)
        begin
            rsp_seen <= rsp_seen + 1;
        end
    end

    task automatic check_value(
        input logic [31:0] actual,
        input logic [31:0] expected,
        input string       what
    );
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    function automatic word_t expected_word(input addr_t a);
        word_t x;
        x = a ^ 32'hc0de_0000;
        return {x[26:0], x[31:27]};
    endfunction

    // few lines and tags so hits, evictions and error fetches all occur
    function automatic addr_t pick_addr();
        int    sel;
        addr_t line;
        sel  = $urandom_range(9, 0);
        line = addr_t'($urandom_range(7, 0)) << 2;
        if (sel == 9)
        begin
            return 32'hc000_0400 + line;
        end
        case (sel % 3)
            0: return 32'h0000_1000 + line;
            1: return 32'h0002_3000 + line;
            default: return 32'h4010_0000 + line;
        endcase
    endfunction

    task automatic clear_model();
        for (int i = 0; i < LINES; i++)
        begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
    endtask

    task automatic do_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        clear_model();
    endtask

    task automatic fetch(input addr_t addr);
        logic [INDEX_BITS-1:0] idx;
        addr_t                 tag;
        logic                  predict_hit;
        logic                  is_err;
        int                    ar_before;
        int                    edges;
        idx         = addr[INDEX_BITS+1:2];
        tag         = addr >> (INDEX_BITS + 2);
        predict_hit = model_valid[idx] && (model_tag[idx] == tag);
        is_err      = (addr[31:30] == 2'b11);
        @(posedge clk);
        cpu_req_valid <= 1'b1;
        cpu_req_addr  <= addr;
        do
        begin
            @(posedge clk);
        end
        while (!cpu_req_ready);
        cpu_req_valid <= 1'b0;
        ar_before = ar_count;
        edges     = 0;
        do
        begin
            @(posedge clk);
            edges++;
        end
        while (!cpu_rsp_valid);
        rsp_taken++;
        check_value(cpu_rsp_data, expected_word(addr), "response data");
        check_value(32'(cpu_rsp_err), 32'(is_err), "response error flag");
        if (predict_hit)
        begin
            hits++;
            check_value(32'(edges), 32'd2, "hit latency");
            check_value(32'(ar_count - ar_before), 32'd0, "read requests on a hit");
        end
        else
        begin
            misses++;
            check_value(32'(ar_count - ar_before), 32'd1, "read requests on a miss");
            check_value(last_araddr, addr, "refill address");
            if (!is_err)
            begin
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'hdace_473e));
        rst           <= 1'b1;
        flush         <= 1'b0;
        cpu_req_valid <= 1'b0;
        cpu_req_addr  <= '0;
        clear_model();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value(32'(cpu_req_ready), 32'd1, "ready after reset");
        check_value(32'(m_arvalid), 32'd0, "arvalid after reset");
        check_value(32'(cpu_rsp_valid), 32'd0, "response valid after reset");
        for (int i = 0; i < NUM_REQ; i++)
        begin
            if (i > 0 && i % FLUSH_EVERY == 0)
            begin
                do_flush();
            end
            fetch(pick_addr());
        end
        repeat (5) @(posedge clk);
        check_value(32'(rsp_seen), 32'(rsp_taken), "response count");
        $display("requests %0d hits %0d misses %0d errors %0d", rsp_taken, hits, misses, errors);
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/icache_pkg.sv
logic/ram_if.sv
logic/icache_array.sv
logic/icache_ctrl.sv
logic/icache_top.sv
bench/axi_mem_model.sv
bench/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
# builds the icache testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_icache \
    -Mdir "$build_dir" \
    -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_icache" | tee "$log"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error status"
    exit 1
fi

if [ ! -s "$log" ]; then
    echo "simulation log is missing or empty"
    exit 1
fi

if grep -q "Test FAILED" "$log"; then
    exit 1
fi
exit 0
